/* flist.f */
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_controller.sv
hw/alu.sv
hw/register_file.sv
hw/imm_extend.sv
hw/pc_unit.sv
hw/cpu_core.sv
verif/cpu_tb.sv

/* hw/alu.sv */
`default_nettype none
`include "cpu_settings.svh"

module alu import cpu_pkg::*; (
	input  wire inst_fields_t fields,
	input  wire ctrl_t        ctrl,
	input  wire word_t        ra_data,
	input  wire word_t        rb_data,
	input  wire word_t        imm_value,
	output word_t             result,
	output logic              zero
);

	word_t src2;
	logic [4:0] op;
	logic [4:0] shamt;
	logic [63:0] rot;

	always_comb begin
		case (ctrl.select_alu_src2)
			`ALUSRC2_IMM:  src2 = imm_value;
			`ALUSRC2_LSW:  src2 = rb_data << fields.sv;
			`ALUSRC2_LSWI: src2 = {{15{fields.imm15[14]}}, fields.imm15, 2'b00};
			default:       src2 = rb_data;
		endcase
	end

	// operation reuses the base sub-op codes
	always_comb begin
		if (ctrl.select_alu_src2 == `ALUSRC2_LSW || ctrl.select_alu_src2 == `ALUSRC2_LSWI) begin
			op = `ADD;
		end else if (ctrl.select_alu_src2 == `ALUSRC2_BENX) begin
			op = `SUB;
		end else if (fields.opcode == `TY_BASE) begin
			op = fields.sub_op_base;
		end else if (fields.opcode == `ORI) begin
			op = `OR;
		end else if (fields.opcode == `XORI) begin
			op = `XOR;
		end else begin
			op = `ADD;
		end
	end

	assign shamt = src2[4:0];
	assign rot = {ra_data, ra_data} >> shamt;

	always_comb begin
		case (op)
			`SUB:    result = ra_data - src2;
			`AND:    result = ra_data & src2;
			`OR:     result = ra_data | src2;
			`XOR:    result = ra_data ^ src2;
			`SRLI:   result = ra_data >> shamt;
			`SLLI:   result = ra_data << shamt;
			`ROTRI:  result = rot[31:0];
			default: result = ra_data + src2;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* hw/cpu_controller.sv */
`default_nettype none
`include "cpu_settings.svh"

module cpu_controller import cpu_pkg::*; (
	input  wire logic   clock,
	input  wire logic   reset,
	input  wire word_t  instruction,
	input  wire logic   alu_zero,
	output inst_fields_t fields,
	output ctrl_t       ctrl,
	output logic        im_read
);

	cpu_state_t state;
	cpu_state_t state_next;
	word_t instr_q;
	logic zero_q;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= state_fetch;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		case (state)
			state_fetch:     state_next = state_decode;
			state_decode:    state_next = state_execute;
			state_execute:   state_next = state_memaccess;
			state_memaccess: state_next = state_writeback;
			default:         state_next = state_fetch;
		endcase
	end

	// loaded as fetch ends
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			instr_q <= '0;
		end else if (state == state_fetch) begin
			instr_q <= instruction;
		end
	end

	// branch compare settles during execute
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			zero_q <= 1'b0;
		end else if (state == state_execute) begin
			zero_q <= alu_zero;
		end
	end

	assign fields = '{
		opcode:      instr_q[30:25],
		rt_addr:     instr_q[24:20],
		ra_addr:     instr_q[19:15],
		rb_addr:     instr_q[14:10],
		sub_op_base: instr_q[4:0],
		sub_op_ls:   instr_q[7:0],
		sv:          instr_q[9:8],
		imm5:        instr_q[14:10],
		imm14:       instr_q[13:0],
		imm15:       instr_q[14:0],
		imm20:       instr_q[19:0],
		imm24:       instr_q[23:0]
	};

	assign im_read = ctrl.enable_fetch;

	always_comb begin
		ctrl = '0;
		ctrl.enable_fetch = (state == state_fetch);
		ctrl.enable_decode = (state == state_decode);
		ctrl.enable_execute = (state == state_execute);
		ctrl.enable_memaccess = (state == state_memaccess);
		ctrl.enable_writeback = (state == state_writeback);
		// unknown codes fall through as a no-op
		ctrl.select_alu_src2 = `ALUSRC2_UNKNOWN;
		ctrl.select_imm_extend = `IMM_5BIT_ZE;
		ctrl.select_write_reg = `WRREG_ALURESULT;
		ctrl.select_pc = `PC_4;
		case (fields.opcode)
			`TY_BASE: begin
				case (fields.sub_op_base)
					`ADD, `SUB, `AND, `OR, `XOR: begin
						ctrl.select_alu_src2 = `ALUSRC2_RBDATA;
						ctrl.do_reg_write = 1'b1;
					end
					`SRLI, `SLLI, `ROTRI: begin
						ctrl.select_alu_src2 = `ALUSRC2_IMM;
						ctrl.select_imm_extend = `IMM_5BIT_ZE;
						ctrl.do_reg_write = 1'b1;
					end
					default: ;
				endcase
			end
			`ADDI: begin
				ctrl.select_alu_src2 = `ALUSRC2_IMM;
				ctrl.select_imm_extend = `IMM_15BIT_SE;
				ctrl.do_reg_write = 1'b1;
			end
			`ORI, `XORI: begin
				ctrl.select_alu_src2 = `ALUSRC2_IMM;
				ctrl.select_imm_extend = `IMM_15BIT_ZE;
				ctrl.do_reg_write = 1'b1;
			end
			`MOVI: begin
				ctrl.select_alu_src2 = `ALUSRC2_IMM;
				ctrl.select_imm_extend = `IMM_20BIT_SE;
				ctrl.select_write_reg = `WRREG_IMMDATA;
				ctrl.do_reg_write = 1'b1;
			end
			`LWI: begin
				ctrl.select_alu_src2 = `ALUSRC2_LSWI;
				ctrl.select_write_reg = `WRREG_LWX;
				ctrl.do_dm_read = 1'b1;
				ctrl.do_reg_write = 1'b1;
			end
			`SWI: begin
				ctrl.select_alu_src2 = `ALUSRC2_LSWI;
				ctrl.do_dm_write = 1'b1;
			end
			`TY_LS: begin
				if (fields.sub_op_ls == `LW) begin
					ctrl.select_alu_src2 = `ALUSRC2_LSW;
					ctrl.select_write_reg = `WRREG_LWX;
					ctrl.do_dm_read = 1'b1;
					ctrl.do_reg_write = 1'b1;
				end else if (fields.sub_op_ls == `SW) begin
					ctrl.select_alu_src2 = `ALUSRC2_LSW;
					ctrl.do_dm_write = 1'b1;
				end
			end
			`TY_B: begin
				ctrl.select_alu_src2 = `ALUSRC2_BENX;
				// bit 14 picks beq or bne
				if ((instr_q[14] == `BEQ && zero_q) || (instr_q[14] == `BNE && !zero_q)) begin
					ctrl.select_pc = `PC_14BIT;
				end
			end
			`JJ: begin
				ctrl.select_pc = `PC_24BIT;
			end
			default: ;
		endcase
	end

	// the word latched at the end of fetch must be defined
	a_instr_known: assert property (@(posedge clock) disable iff (reset)
		ctrl.enable_fetch |-> !$isunknown(instruction));

	a_dm_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(ctrl.do_dm_read && ctrl.do_dm_write));

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`default_nettype none
`include "cpu_settings.svh"

module cpu_core import cpu_pkg::*; (
	input  wire logic  clock,
	input  wire logic  reset,
	output word_t      im_addr,
	output logic       im_read,
	input  wire word_t instruction,
	output word_t      dm_addr,
	output logic       dm_read,
	output logic       dm_write,
	output word_t      dm_wdata,
	input  wire word_t dm_rdata
);

	inst_fields_t fields;
	ctrl_t ctrl;
	word_t pc;
	word_t ra_data;
	word_t rb_data;
	word_t imm_value;
	word_t alu_result;
	logic alu_zero;
	word_t alu_q;
	word_t load_q;
	word_t wb_data;
	reg_addr_t rb_addr;

	cpu_controller u_controller (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.alu_zero(alu_zero),
		.fields(fields),
		.ctrl(ctrl),
		.im_read(im_read)
	);

	// branches compare ra with rt; stores send rt out during memory access
	assign rb_addr = (fields.opcode == `TY_B || ctrl.enable_memaccess) ?
		fields.rt_addr : fields.rb_addr;

	register_file u_regs (
		.clock(clock),
		.reset(reset),
		.ra_addr(fields.ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(fields.rt_addr),
		.write_enable(ctrl.do_reg_write & ctrl.enable_writeback),
		.write_data(wb_data),
		.ra_data(ra_data),
		.rb_data(rb_data)
	);

	imm_extend u_imm (
		.fields(fields),
		.select_imm_extend(ctrl.select_imm_extend),
		.imm_value(imm_value)
	);

	alu u_alu (
		.fields(fields),
		.ctrl(ctrl),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.imm_value(imm_value),
		.result(alu_result),
		.zero(alu_zero)
	);

	pc_unit u_pc (
		.clock(clock),
		.reset(reset),
		.enable(ctrl.enable_writeback),
		.select_pc(ctrl.select_pc),
		.fields(fields),
		.pc(pc)
	);

	always_ff @(posedge clock) begin
		if (ctrl.enable_execute) begin
			alu_q <= alu_result;
		end
		if (ctrl.enable_memaccess) begin
			load_q <= dm_rdata;
		end
	end

	always_comb begin
		case (ctrl.select_write_reg)
			`WRREG_IMMDATA: wb_data = imm_value;
			`WRREG_LWX:     wb_data = load_q;
			default:        wb_data = alu_q;
		endcase
	end

	assign im_addr = pc;
	assign dm_addr = alu_q;
	assign dm_wdata = rb_data;
	assign dm_read = ctrl.do_dm_read & ctrl.enable_memaccess;
	assign dm_write = ctrl.do_dm_write & ctrl.enable_memaccess;

endmodule

`default_nettype wire

/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;

	// mux select widths
	typedef logic [2:0] alu_src2_sel_t;
	typedef logic [1:0] imm_sel_t;
	typedef logic [1:0] wr_sel_t;
	typedef logic [1:0] pc_sel_t;

	typedef enum logic [2:0] {
		state_fetch,
		state_decode,
		state_execute,
		state_memaccess,
		state_writeback
	} cpu_state_t;

	// slices of the latched instruction
	typedef struct packed {
		opcode_t     opcode;
		reg_addr_t   rt_addr;
		reg_addr_t   ra_addr;
		reg_addr_t   rb_addr;
		logic [4:0]  sub_op_base;
		logic [7:0]  sub_op_ls;
		logic [1:0]  sv;
		logic [4:0]  imm5;
		logic [13:0] imm14;
		logic [14:0] imm15;
		logic [19:0] imm20;
		logic [23:0] imm24;
	} inst_fields_t;

	typedef struct packed {
		alu_src2_sel_t select_alu_src2;
		imm_sel_t      select_imm_extend;
		wr_sel_t       select_write_reg;
		pc_sel_t       select_pc;
		logic          do_dm_read;
		logic          do_dm_write;
		logic          do_reg_write;
		logic          enable_fetch;
		logic          enable_decode;
		logic          enable_execute;
		logic          enable_memaccess;
		logic          enable_writeback;
	} ctrl_t;

endpackage

`default_nettype wire

/* hw/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// major opcodes, instruction bits 30:25
`define TY_BASE 6'b100000
`define ADDI    6'b101000
`define ORI     6'b101100
`define XORI    6'b101011
`define MOVI    6'b100010
`define LWI     6'b000010
`define SWI     6'b001010
`define TY_LS   6'b011100
`define TY_B    6'b100110
`define JJ      6'b100100

// base sub-ops, bits 4:0
`define ADD   5'b00000
`define SUB   5'b00001
`define AND   5'b00010
`define XOR   5'b00011
`define OR    5'b00100
`define SLLI  5'b01000
`define SRLI  5'b01001
`define ROTRI 5'b01011

// load/store sub-ops, bits 7:0
`define LW 8'b00000010
`define SW 8'b00001010

// branch sub-op, bit 14
`define BEQ 1'b0
`define BNE 1'b1

`define ALUSRC2_RBDATA  3'b000
`define ALUSRC2_IMM     3'b001
`define ALUSRC2_LSW     3'b010
`define ALUSRC2_LSWI    3'b011
`define ALUSRC2_BENX    3'b100
`define ALUSRC2_UNKNOWN 3'b111

`define IMM_5BIT_ZE  2'b00
`define IMM_15BIT_SE 2'b01
`define IMM_15BIT_ZE 2'b10
`define IMM_20BIT_SE 2'b11

`define WRREG_ALURESULT 2'b00
`define WRREG_IMMDATA   2'b01
`define WRREG_LWX       2'b10

`define PC_4     2'b00
`define PC_14BIT 2'b01
`define PC_24BIT 2'b10

`endif

/* hw/imm_extend.sv */
`default_nettype none
`include "cpu_settings.svh"

module imm_extend import cpu_pkg::*; (
	input  wire inst_fields_t fields,
	input  wire imm_sel_t     select_imm_extend,
	output word_t             imm_value
);

	always_comb begin
		case (select_imm_extend)
			`IMM_5BIT_ZE: begin
				imm_value = {27'b0, fields.imm5};
			end
			`IMM_15BIT_SE: begin
				imm_value = {{17{fields.imm15[14]}}, fields.imm15};
			end
			`IMM_15BIT_ZE: begin
				imm_value = {17'b0, fields.imm15};
			end
			default: begin
				// movi
				imm_value = {{12{fields.imm20[19]}}, fields.imm20};
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/pc_unit.sv */
`default_nettype none
`include "cpu_settings.svh"

module pc_unit import cpu_pkg::*; (
	input  wire logic         clock,
	input  wire logic         reset,
	input  wire logic         enable,
	input  wire pc_sel_t      select_pc,
	input  wire inst_fields_t fields,
	output word_t             pc
);

	word_t pc_next;

	// offsets count halfwords
	always_comb begin
		case (select_pc)
			`PC_14BIT: pc_next = pc + {{17{fields.imm14[13]}}, fields.imm14, 1'b0};
			`PC_24BIT: pc_next = pc + {{7{fields.imm24[23]}}, fields.imm24, 1'b0};
			default:   pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (enable) begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

/* hw/register_file.sv */
`default_nettype none

module register_file import cpu_pkg::*; (
	input  wire logic      clock,
	input  wire logic      reset,
	input  wire reg_addr_t ra_addr,
	input  wire reg_addr_t rb_addr,
	input  wire reg_addr_t rt_addr,
	input  wire logic      write_enable,
	input  wire word_t     write_data,
	output word_t          ra_data,
	output word_t          rb_data
);

	word_t regs [32];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && rt_addr != '0) begin
			regs[rt_addr] <= write_data;
		end
	end

	// r0 is hardwired
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module cpu_tb -o cpu_sim

output=$(./obj_dir/cpu_sim || true)
echo "$output"

if grep -q "Regression passed" <<< "$output"; then
	exit 0
else
	exit 1
fi

/* verif/cpu_stimulus.txt */
# P word: program word at the next address; D addr data: initial data word
# S addr data: expected store in order; H addr: halt address of the jump-to-self
P 04100000
P 04200001
P 04300002
P 40408800
P 14400020
P 40408801
P 14400021
P 40408C02
P 14400022
P 40408C04
P 14400023
P 40408C03
P 14400024
P 40409009
P 14400025
P 4040A008
P 14400026
P 4040A00B
P 14400027
P 5050FFF8
P 14500028
P 58514100
P 14500029
P 5651FFFF
P 1450002A
P 44680001
P 1460002B
P 04700003
P 44800001
P 38902302
P 44A000A8
P 3875230A
P 14950003
P 4C840004
P 14100030
P 4C740004
P 14200031
P 4C744004
P 14100032
P 48000004
P 14100033
P 14600034
P 48000000
D 00 12345678
D 04 0000000F
D 08 F0F0F0F0
D 0C 80000001
S 80 12345687
S 84 12345669
S 88 10305070
S 8C F2F4F6F8
S 90 E2C4A688
S 94 01234567
S 98 34567800
S 9C 78123456
S A0 12345670
S A4 0000410F
S A8 F0F08F0F
S AC FFF80001
S B0 80000001
S B4 F0F0F0F0
S C4 0000000F
S D0 FFF80001
H A8

/* verif/cpu_tb.sv */
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int mem_words = 64;
	localparam int halt_timeout = 2000;

	logic  clock;
	logic  reset;
	word_t im_addr;
	logic  im_read;
	word_t instruction;
	word_t dm_addr;
	logic  dm_read;
	logic  dm_write;
	word_t dm_wdata;
	word_t dm_rdata;

	word_t imem [mem_words];
	word_t dmem [mem_words];
	word_t exp_addr [$];
	word_t exp_data [$];
	word_t halt_addr;
	logic [31:0] lfsr_state;
	int store_index;
	word_t fetch_gap;
	logic fetch_seen;

	cpu_core uut (
		.clock(clock),
		.reset(reset),
		.im_addr(im_addr),
		.im_read(im_read),
		.instruction(instruction),
		.dm_addr(dm_addr),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.dm_wdata(dm_wdata),
		.dm_rdata(dm_rdata)
	);

	// both memories answer in the same cycle
	assign instruction = imem[im_addr[7:2]];
	// data reads need the strobe
	assign dm_rdata = dm_read ? dmem[dm_addr[7:2]] : '0;

	always #50 clock = ~clock;

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			report_failure($sformatf("error: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			report_failure($sformatf("error: %s expected %b actual %b", name, expected, actual));
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic random_word(output word_t w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	task automatic fill_memories();
		word_t w;
		for (int i = 0; i < mem_words; i++) begin
			random_word(w);
			dmem[i] = w ^ (32'(i) << 2);
			// opcode zero, so stray words are no-ops
			imem[i] = 32'(i);
		end
	endtask

	task automatic read_stimulus();
		int fd;
		int r;
		int pc_index;
		byte tag;
		string line;
		word_t a;
		word_t d;
		logic done;
		fd = $fopen("verif/cpu_stimulus.txt", "r");
		if (fd == 0) begin
			report_failure("could not open the stimulus file");
		end
		pc_index = 0;
		done = 1'b0;
		while (!done) begin
			r = $fscanf(fd, " %c", tag);
			if (r != 1) begin
				done = 1'b1;
			end else if (tag == "#") begin
				r = $fgets(line, fd);
			end else if (tag == "P") begin
				r = $fscanf(fd, "%h", d);
				imem[pc_index] = d;
				pc_index++;
			end else if (tag == "D") begin
				r = $fscanf(fd, "%h %h", a, d);
				dmem[a[7:2]] = d;
			end else if (tag == "S") begin
				r = $fscanf(fd, "%h %h", a, d);
				exp_addr.push_back(a);
				exp_data.push_back(d);
			end else if (tag == "H") begin
				r = $fscanf(fd, "%h", halt_addr);
			end else begin
				report_failure("unknown record in the stimulus file");
			end
		end
		$fclose(fd);
	endtask

	// store checker and data memory write port
	always @(posedge clock) begin
		if (reset) begin
			store_index <= 0;
		end else if (dm_write) begin
			if (store_index >= exp_data.size()) begin
				report_failure($sformatf("store to %h that the program should not make",
					dm_addr));
			end else begin
				check_word($sformatf("store %0d address", store_index), exp_addr[store_index],
					dm_addr);
				check_word($sformatf("store %0d data", store_index), exp_data[store_index],
					dm_wdata);
				check_flag("dm_read during store", 1'b0, dm_read);
				dmem[dm_addr[7:2]] = dm_wdata;
				store_index <= store_index + 1;
			end
		end
	end

	// one fetch every five cycles
	always @(posedge clock) begin
		if (reset) begin
			fetch_gap <= '0;
			fetch_seen <= 1'b0;
		end else if (im_read) begin
			if (fetch_seen) begin
				check_word("fetch spacing", 32'd5, fetch_gap);
			end
			fetch_gap <= 32'd1;
			fetch_seen <= 1'b1;
		end else begin
			fetch_gap <= fetch_gap + 1;
		end
	end

	initial begin
		int cycles;
		int halt_hits;
		clock = 1'b0;
		reset = 1'b1;
		halt_addr = '0;
		lfsr_state = 32'h9485;
		fill_memories();
		read_stimulus();

		repeat (5) begin
			@(posedge clock);
			check_flag("dm_write in reset", 1'b0, dm_write);
			check_flag("dm_read in reset", 1'b0, dm_read);
			check_word("im_addr in reset", 32'h0, im_addr);
		end
		#1 reset = 1'b0;

		@(posedge clock);
		check_flag("im_read after reset", 1'b1, im_read);
		check_word("first im_addr", 32'h0, im_addr);
		check_flag("dm_write after reset", 1'b0, dm_write);
		check_flag("dm_read after reset", 1'b0, dm_read);

		// the jump-to-self must be fetched twice
		cycles = 0;
		halt_hits = 0;
		while (halt_hits < 2) begin
			@(posedge clock);
			cycles++;
			if (im_read && im_addr == halt_addr) begin
				halt_hits++;
			end
			if (cycles > halt_timeout) begin
				report_failure("timeout: the program never reached the halt address");
			end
		end

		if (store_index == exp_data.size()) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("store count %0d does not match the expected %0d", store_index,
				exp_data.size());
			$display("Regression failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire
